// File: Makefile
sim:
	verilator --binary --assert -f vlog.f --top-module tb_idu -o sim_tb
	./obj_dir/sim_tb 2>&1 | tee sim.log
	@if grep -q "Done: errors found" sim.log; then exit 1; fi
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic o_clk,
  output logic o_reset
);
  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;  // 20 ns period
  end

  initial begin
    o_reset = 1'b1;
    repeat (3) @(posedge o_clk);
    @(negedge o_clk);
    o_reset = 1'b0;
  end
endmodule

// File: bench/tb_idu.sv
`timescale 1ns/1ps
`include "idu_defines.svh"

module tb_idu;
  import idu_pkg::*;

  localparam int NUM_CYCLES  = 3000;
  localparam int RESET_LIMIT = 10;

  typedef struct packed {
    logic       valid;
    logic       mem_we;
    logic       mem_en;
    logic [1:0] mem_width;
    logic       mem_unsigned;
    logic       reg_wen;
    logic       mem_to_reg;
    logic       jump;
    logic       jalr;
    logic       branch;
    logic [3:0] alu_op;
    logic [1:0] src1;
    logic [1:0] src2;
    logic       ebreak;
    logic       ecall;
    logic       mret;
    logic       csr_we;
    logic [1:0] csr_op;
    logic       illegal;
  } ctrl_t;

  logic               i_clk;
  logic               i_reset;
  logic [`ILEN-1:0]   i_inst;
  logic               i_inst_valid;
  logic               o_valid;
  logic [`REG_AW-1:0] o_rs1_addr;
  logic [`REG_AW-1:0] o_rs2_addr;
  logic [`REG_AW-1:0] o_rd_addr;
  logic [2:0]         o_funct3;
  logic [`CSR_AW-1:0] o_csr_addr;
  logic [`XLEN-1:0]   o_imm;
  logic               o_mem_we;
  logic               o_mem_en;
  logic [1:0]         o_mem_width;
  logic               o_mem_unsigned;
  logic               o_reg_wen;
  logic               o_mem_to_reg;
  logic               o_jump;
  logic               o_jalr;
  logic               o_branch;
  logic [3:0]         o_alu_op;
  logic [1:0]         o_alu_src1_sel;
  logic [1:0]         o_alu_src2_sel;
  logic               o_ebreak;
  logic               o_ecall;
  logic               o_mret;
  logic               o_csr_we;
  logic [1:0]         o_csr_op;
  logic               o_illegal;

  inst_u            exp_word;
  logic [`XLEN-1:0] exp_imm;
  ctrl_t            exp_ctrl;
  int               cycles;

  tb_clock u_clock (
    .o_clk   (i_clk),
    .o_reset (i_reset)
  );

  idu_top i_dut (.*);

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  function automatic ctrl_t safe_ctrl();
    ctrl_t c;
    c           = '0;
    c.mem_width = `MEM_WORD;
    c.alu_op    = `ALU_ADD;
    c.src1      = `SRC_REG;
    c.src2      = `SRC_IMM;
    c.csr_op    = `CSR_NONE;
    return c;
  endfunction

  function automatic logic [3:0] base_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? `ALU_SUB : `ALU_ADD;
      3'b001:  return `ALU_SLL;
      3'b010:  return `ALU_SLT;
      3'b011:  return `ALU_SLTU;
      3'b100:  return `ALU_XOR;
      3'b101:  return alt ? `ALU_SRA : `ALU_SRL;
      3'b110:  return `ALU_OR;
      default: return `ALU_AND;
    endcase
  endfunction

  function automatic logic [1:0] mem_size(input logic [2:0] f3);
    if (f3[1:0] == 2'b00)
      return `MEM_BYTE;
    else if (f3[1:0] == 2'b01)
      return `MEM_HALF;
    return `MEM_WORD;
  endfunction

  // Reference decode table
  function automatic ctrl_t ctrl_model(input inst_u w, input logic valid, input logic rst);
    ctrl_t      c;
    logic       ok;
    logic [2:0] f3;
    logic [6:0] f7;
    c  = safe_ctrl();
    f3 = w.r.funct3;
    f7 = w.r.funct7;
    ok = 1'b1;
    if (rst || !valid)
      return c;
    c.valid = 1'b1;
    case (w.r.opcode)
      `OPC_LOAD: begin
        ok             = f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
        c.mem_en       = 1'b1;
        c.mem_width    = mem_size(f3);
        c.mem_unsigned = f3[2];
        c.reg_wen      = 1'b1;
        c.mem_to_reg   = 1'b1;
      end
      `OPC_STORE: begin
        ok          = f3 inside {3'b000, 3'b001, 3'b010};
        c.mem_we    = 1'b1;
        c.mem_en    = 1'b1;
        c.mem_width = mem_size(f3);
      end
      `OPC_OPIMM: begin
        if (f3 == 3'b001)
          ok = (f7 == `FUNCT7_STD);
        if (f3 == 3'b101)
          ok = (f7 == `FUNCT7_STD) || (f7 == `FUNCT7_ALT);
        c.reg_wen = 1'b1;
        c.alu_op  = base_alu(f3, (f3 == 3'b101) && (f7 == `FUNCT7_ALT));
      end
      `OPC_OP: begin
        ok = (f7 == `FUNCT7_STD) ||
             ((f7 == `FUNCT7_ALT) && ((f3 == 3'b000) || (f3 == 3'b101)));
        c.reg_wen = 1'b1;
        c.alu_op  = base_alu(f3, f7 == `FUNCT7_ALT);
        c.src2    = `SRC_REG;
      end
      `OPC_BRANCH: begin
        c.branch = 1'b1;
        c.src2   = `SRC_REG;
        case (f3)
          3'b000, 3'b001: c.alu_op = `ALU_SUB;   // BEQ, BNE
          3'b100, 3'b101: c.alu_op = `ALU_SLT;   // BLT, BGE
          3'b110, 3'b111: c.alu_op = `ALU_SLTU;  // BLTU, BGEU
          default:        ok = 1'b0;
        endcase
      end
      `OPC_LUI: begin
        c.reg_wen = 1'b1;
        c.alu_op  = `ALU_LUI;
        c.src1    = `SRC_ZERO;
      end
      `OPC_AUIPC: begin
        c.reg_wen = 1'b1;
        c.src1    = `SRC_PC;
      end
      `OPC_JAL: begin
        c.reg_wen = 1'b1;
        c.jump    = 1'b1;
        c.src1    = `SRC_PC;
      end
      `OPC_JALR: begin
        ok        = (f3 == 3'b000);
        c.reg_wen = 1'b1;
        c.jump    = 1'b1;
        c.jalr    = 1'b1;
      end
      `OPC_SYSTEM: begin
        c.src2 = `SRC_REG;
        if (f3 == 3'b000) begin
          c.ecall  = (w.i.imm12 == `SYS_ECALL);
          c.ebreak = (w.i.imm12 == `SYS_EBREAK);
          c.mret   = (w.i.imm12 == `MRET_INST);
          ok       = c.ecall || c.ebreak || c.mret;
        end else if (f3 == 3'b001 || f3 == 3'b010) begin
          c.csr_we  = 1'b1;
          c.csr_op  = (f3 == 3'b001) ? `CSR_RW : `CSR_RS;
          c.reg_wen = (w.r.rd != 5'd0);
        end else begin
          ok = 1'b0;
        end
      end
      default: ok = 1'b0;
    endcase
    if (!ok) begin
      c         = safe_ctrl();
      c.valid   = 1'b1;
      c.illegal = 1'b1;
    end
    return c;
  endfunction

  function automatic logic [`XLEN-1:0] imm_model(input logic [`ILEN-1:0] w);
    case (w[6:0])
      `OPC_OPIMM, `OPC_LOAD, `OPC_JALR:
        return {{20{w[31]}}, w[31:20]};
      `OPC_STORE:
        return {{20{w[31]}}, w[31:25], w[11:7]};
      `OPC_BRANCH:
        return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      `OPC_LUI, `OPC_AUIPC:
        return {w[31:12], 12'h000};
      `OPC_JAL:
        return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      `OPC_OP:
        return '0;
      default:
        return 32'd1;
    endcase
  endfunction

  function automatic logic [6:0] random_opcode();
    case ($urandom_range(0, 9))
      0:       return `OPC_LOAD;
      1:       return `OPC_STORE;
      2:       return `OPC_OPIMM;
      3:       return `OPC_OP;
      4:       return `OPC_BRANCH;
      5:       return `OPC_LUI;
      6:       return `OPC_AUIPC;
      7:       return `OPC_JAL;
      8:       return `OPC_JALR;
      default: return `OPC_SYSTEM;
    endcase
  endfunction

  // Legal instruction with random fields
  function automatic logic [`ILEN-1:0] legal_word();
    inst_u      w;
    logic [2:0] f3;
    w        = $urandom;
    f3       = 3'($urandom);
    w.r.opcode = random_opcode();
    case (w.r.opcode)
      `OPC_LOAD: begin
        f3 = 3'($urandom_range(0, 4));
        if (f3 > 3'd2)
          f3 = f3 + 3'd1;  // Skip 3
      end
      `OPC_STORE:  f3 = 3'($urandom_range(0, 2));
      `OPC_OPIMM: begin
        if (f3 == 3'b001)
          w.r.funct7 = `FUNCT7_STD;
        if (f3 == 3'b101)
          w.r.funct7 = $urandom_range(0, 1) ? `FUNCT7_ALT : `FUNCT7_STD;
      end
      `OPC_OP: begin
        if (((f3 == 3'b000) || (f3 == 3'b101)) && ($urandom_range(0, 1) == 1))
          w.r.funct7 = `FUNCT7_ALT;
        else
          w.r.funct7 = `FUNCT7_STD;
      end
      `OPC_BRANCH: begin
        f3 = 3'($urandom_range(0, 5));
        if (f3 >= 3'd2)
          f3 = f3 + 3'd2;  // Skip 2 and 3
      end
      `OPC_JALR:   f3 = 3'b000;
      `OPC_SYSTEM: begin
        case ($urandom_range(0, 4))
          0: begin
            f3        = 3'b000;
            w.i.imm12 = `SYS_ECALL;
          end
          1: begin
            f3        = 3'b000;
            w.i.imm12 = `SYS_EBREAK;
          end
          2: begin
            f3        = 3'b000;
            w.i.imm12 = `MRET_INST;
          end
          default: begin
            f3 = 3'($urandom_range(1, 2));  // CSRRW or CSRRS
            if ($urandom_range(0, 3) == 0)
              w.r.rd = 5'd0;
          end
        endcase
      end
      default: ;
    endcase
    w.r.funct3 = f3;
    return w;
  endfunction

  task automatic drive_next();
    int unsigned pick;
    pick = $urandom_range(0, 99);
    if (pick < 60)
      i_inst = legal_word();
    else if (pick < 85)
      i_inst = {25'($urandom_range(0, 32'h01ff_ffff)), random_opcode()};  // Random funct fields
    else
      i_inst = $urandom;
    i_inst_valid = ($urandom_range(0, 99) < 80);
  endtask

  function automatic ctrl_t observed_ctrl();
    ctrl_t c;
    c.valid        = o_valid;
    c.mem_we       = o_mem_we;
    c.mem_en       = o_mem_en;
    c.mem_width    = o_mem_width;
    c.mem_unsigned = o_mem_unsigned;
    c.reg_wen      = o_reg_wen;
    c.mem_to_reg   = o_mem_to_reg;
    c.jump         = o_jump;
    c.jalr         = o_jalr;
    c.branch       = o_branch;
    c.alu_op       = o_alu_op;
    c.src1         = o_alu_src1_sel;
    c.src2         = o_alu_src2_sel;
    c.ebreak       = o_ebreak;
    c.ecall        = o_ecall;
    c.mret         = o_mret;
    c.csr_we       = o_csr_we;
    c.csr_op       = o_csr_op;
    c.illegal      = o_illegal;
    return c;
  endfunction

  task automatic check_fields(input inst_u exp);
    if (o_rs1_addr !== exp.r.rs1 || o_rs2_addr !== exp.r.rs2 || o_rd_addr !== exp.r.rd ||
        o_funct3 !== exp.r.funct3 || o_csr_addr !== exp.i.imm12)
      report_mismatch($sformatf("fields of word %h: rs1 %h rs2 %h rd %h f3 %h csr %h",
                                exp, o_rs1_addr, o_rs2_addr, o_rd_addr, o_funct3,
                                o_csr_addr));
  endtask

  task automatic check_imm(input logic [`XLEN-1:0] exp);
    if (o_imm !== exp)
      report_mismatch($sformatf("immediate exp %h got %h", exp, o_imm));
  endtask

  task automatic check_ctrl(input ctrl_t exp);
    ctrl_t got;
    got = observed_ctrl();
    if (got !== exp)
      report_mismatch($sformatf("control for word %h exp %h got %h", exp_word, exp, got));
  endtask

  // Sample at the rising edge, check and drive at the falling edge
  task automatic step();
    @(posedge i_clk);
    exp_word = i_inst;
    exp_imm  = imm_model(i_inst);
    exp_ctrl = ctrl_model(i_inst, i_inst_valid, i_reset);
    @(negedge i_clk);
    check_fields(exp_word);
    check_imm(exp_imm);
    check_ctrl(exp_ctrl);
    drive_next();
  endtask

  initial begin
    i_inst       = '0;
    i_inst_valid = 1'b0;
    void'($urandom(8276));
    cycles = 0;
    while (i_reset !== 1'b0 && cycles < RESET_LIMIT) begin
      step();
      cycles++;
    end
    if (i_reset !== 1'b0)
      report_failure("reset was still high after the wait limit");
    repeat (NUM_CYCLES) step();
    $display("Done: no errors");
    $finish;
  end
endmodule

// File: rtl/ctrl_decode.sv
`timescale 1ns/1ps
`include "idu_defines.svh"

module ctrl_decode (
  input idu_pkg::inst_u i_inst,
  dec_if.src            ctrl
);
  import idu_pkg::*;

  r_fmt_t w_r;
  i_fmt_t w_i;
  logic   w_f7_std;
  logic   w_f7_alt;
  logic   w_shift;
  logic   w_alt_ok;
  logic   w_illegal;

  function automatic logic [3:0] alu_of(input logic [2:0] f3, input logic alt);
    logic [3:0] op;
    case (f3)
      3'b000:  op = alt ? `ALU_SUB : `ALU_ADD;
      3'b001:  op = `ALU_SLL;
      3'b010:  op = `ALU_SLT;
      3'b011:  op = `ALU_SLTU;
      3'b100:  op = `ALU_XOR;
      3'b101:  op = alt ? `ALU_SRA : `ALU_SRL;
      3'b110:  op = `ALU_OR;
      default: op = `ALU_AND;
    endcase
    return op;
  endfunction

  function automatic logic [1:0] width_of(input logic [2:0] f3);
    logic [1:0] w;
    case (f3[1:0])
      2'b00:   w = `MEM_BYTE;
      2'b01:   w = `MEM_HALF;
      default: w = `MEM_WORD;
    endcase
    return w;
  endfunction

  assign w_r      = i_inst.r;
  assign w_i      = i_inst.i;
  assign w_f7_std = (w_r.funct7 == `FUNCT7_STD);
  assign w_f7_alt = (w_r.funct7 == `FUNCT7_ALT);
  assign w_shift  = (w_r.funct3[1:0] == 2'b01);  // SLL or SRL/SRA
  assign w_alt_ok = (w_r.funct3 == 3'b000) || (w_r.funct3 == 3'b101);

  // Legality only
  always_comb begin
    w_illegal = 1'b0;
    case (w_r.opcode)
      `OPC_LOAD:   w_illegal = (w_r.funct3[1:0] == 2'b11) || (w_r.funct3 == 3'b110);
      `OPC_STORE:  w_illegal = w_r.funct3[2] || (w_r.funct3[1:0] == 2'b11);
      `OPC_OPIMM:  w_illegal = w_shift && !(w_f7_std || (w_f7_alt && w_r.funct3[2]));
      `OPC_OP:     w_illegal = !(w_f7_std || (w_f7_alt && w_alt_ok));
      `OPC_BRANCH: w_illegal = (w_r.funct3[2:1] == 2'b01);
      `OPC_JALR:   w_illegal = (w_r.funct3 != 3'b000);
      `OPC_LUI,
      `OPC_AUIPC,
      `OPC_JAL:    w_illegal = 1'b0;
      `OPC_SYSTEM: begin
        case (w_r.funct3)
          3'b000:  w_illegal = !((w_i.imm12 == `SYS_ECALL) || (w_i.imm12 == `SYS_EBREAK) ||
                                 (w_i.imm12 == `MRET_INST));
          3'b001,
          3'b010:  w_illegal = 1'b0;  // CSRRW, CSRRS
          default: w_illegal = 1'b1;
        endcase
      end
      default:     w_illegal = 1'b1;
    endcase
  end

  always_comb begin
    ctrl.mem_we       = 1'b0;
    ctrl.mem_en       = 1'b0;
    ctrl.mem_width    = `MEM_WORD;
    ctrl.mem_unsigned = 1'b0;
    ctrl.reg_wen      = 1'b0;
    ctrl.mem_to_reg   = 1'b0;
    ctrl.jump         = 1'b0;
    ctrl.jalr         = 1'b0;
    ctrl.branch       = 1'b0;
    ctrl.alu_op       = `ALU_ADD;
    ctrl.alu_src1_sel = `SRC_REG;
    ctrl.alu_src2_sel = `SRC_IMM;
    ctrl.ebreak       = 1'b0;
    ctrl.ecall        = 1'b0;
    ctrl.mret         = 1'b0;
    ctrl.csr_we       = 1'b0;
    ctrl.csr_op       = `CSR_NONE;
    ctrl.illegal      = w_illegal;
    if (!w_illegal) begin
      case (w_r.opcode)
        `OPC_LOAD: begin
          ctrl.mem_en       = 1'b1;
          ctrl.mem_width    = width_of(w_r.funct3);
          ctrl.mem_unsigned = w_r.funct3[2];  // LBU, LHU
          ctrl.reg_wen      = 1'b1;
          ctrl.mem_to_reg   = 1'b1;
        end
        `OPC_STORE: begin
          ctrl.mem_we    = 1'b1;
          ctrl.mem_en    = 1'b1;
          ctrl.mem_width = width_of(w_r.funct3);
        end
        `OPC_OPIMM: begin
          ctrl.reg_wen = 1'b1;
          ctrl.alu_op  = alu_of(w_r.funct3, w_shift & w_r.funct7[5]);  // SRAI
        end
        `OPC_OP: begin
          ctrl.reg_wen      = 1'b1;
          ctrl.alu_op       = alu_of(w_r.funct3, w_r.funct7[5]);  // SUB, SRA
          ctrl.alu_src2_sel = `SRC_REG;
        end
        `OPC_BRANCH: begin
          ctrl.branch       = 1'b1;
          ctrl.alu_src2_sel = `SRC_REG;
          if (!w_r.funct3[2])
            ctrl.alu_op = `ALU_SUB;  // BEQ, BNE
          else
            ctrl.alu_op = w_r.funct3[1] ? `ALU_SLTU : `ALU_SLT;
        end
        `OPC_LUI: begin
          ctrl.reg_wen      = 1'b1;
          ctrl.alu_op       = `ALU_LUI;
          ctrl.alu_src1_sel = `SRC_ZERO;
        end
        `OPC_AUIPC: begin
          ctrl.reg_wen      = 1'b1;
          ctrl.alu_src1_sel = `SRC_PC;
        end
        `OPC_JAL: begin
          ctrl.reg_wen      = 1'b1;
          ctrl.jump         = 1'b1;
          ctrl.alu_src1_sel = `SRC_PC;
        end
        `OPC_JALR: begin
          ctrl.reg_wen = 1'b1;
          ctrl.jump    = 1'b1;
          ctrl.jalr    = 1'b1;
        end
        `OPC_SYSTEM: begin
          ctrl.alu_src2_sel = `SRC_REG;
          if (w_r.funct3 == 3'b000) begin
            ctrl.ecall  = (w_i.imm12 == `SYS_ECALL);
            ctrl.ebreak = (w_i.imm12 == `SYS_EBREAK);
            ctrl.mret   = (w_i.imm12 == `MRET_INST);
          end else begin
            ctrl.reg_wen = (w_r.rd != '0);  // No write to x0
            ctrl.csr_we  = 1'b1;
            ctrl.csr_op  = w_r.funct3[1] ? `CSR_RS : `CSR_RW;
          end
        end
        default: ;
      endcase
    end
  end
endmodule

// File: rtl/dec_if.sv
`timescale 1ns/1ps
`include "idu_defines.svh"

interface dec_if;
  localparam int OP_W  = $bits(`ALU_ADD);
  localparam int SEL_W = $bits(`SRC_REG);
  localparam int WID_W = $bits(`MEM_WORD);
  localparam int CSR_W = $bits(`CSR_NONE);

  logic             mem_we;
  logic             mem_en;
  logic [WID_W-1:0] mem_width;
  logic             mem_unsigned;
  logic             reg_wen;
  logic             mem_to_reg;
  logic             jump;
  logic             jalr;
  logic             branch;
  logic [OP_W-1:0]  alu_op;
  logic [SEL_W-1:0] alu_src1_sel;
  logic [SEL_W-1:0] alu_src2_sel;
  logic             ebreak;
  logic             ecall;
  logic             mret;
  logic             csr_we;
  logic [CSR_W-1:0] csr_op;
  logic             illegal;

  modport src (
    output mem_we, mem_en, mem_width, mem_unsigned, reg_wen, mem_to_reg, jump, jalr,
           branch, alu_op, alu_src1_sel, alu_src2_sel, ebreak, ecall, mret, csr_we,
           csr_op, illegal
  );

  modport dst (
    input mem_we, mem_en, mem_width, mem_unsigned, reg_wen, mem_to_reg, jump, jalr,
          branch, alu_op, alu_src1_sel, alu_src2_sel, ebreak, ecall, mret, csr_we,
          csr_op, illegal
  );
endinterface

// File: rtl/dec_reg.sv
`timescale 1ns/1ps
`include "idu_defines.svh"

module dec_reg (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic                i_valid,
  input  idu_pkg::inst_u      i_inst,
  input  logic [`XLEN-1:0]    i_imm,
  dec_if.dst                  ctrl,
  output logic                o_valid,
  output logic [`REG_AW-1:0]  o_rs1_addr,
  output logic [`REG_AW-1:0]  o_rs2_addr,
  output logic [`REG_AW-1:0]  o_rd_addr,
  output logic [2:0]          o_funct3,
  output logic [`CSR_AW-1:0]  o_csr_addr,
  output logic [`XLEN-1:0]    o_imm,
  output logic                o_mem_we,
  output logic                o_mem_en,
  output logic [1:0]          o_mem_width,
  output logic                o_mem_unsigned,
  output logic                o_reg_wen,
  output logic                o_mem_to_reg,
  output logic                o_jump,
  output logic                o_jalr,
  output logic                o_branch,
  output logic [3:0]          o_alu_op,
  output logic [1:0]          o_alu_src1_sel,
  output logic [1:0]          o_alu_src2_sel,
  output logic                o_ebreak,
  output logic                o_ecall,
  output logic                o_mret,
  output logic                o_csr_we,
  output logic [1:0]          o_csr_op,
  output logic                o_illegal
);

  // Fields follow the word every cycle
  always_ff @(posedge i_clk) begin
    o_rs1_addr <= i_inst.r.rs1;
    o_rs2_addr <= i_inst.r.rs2;
    o_rd_addr  <= i_inst.r.rd;
    o_funct3   <= i_inst.r.funct3;
    o_csr_addr <= i_inst.i.imm12;
    o_imm      <= i_imm;
  end

  always_ff @(posedge i_clk) begin
    if (i_reset || !i_valid) begin
      o_valid        <= 1'b0;
      o_mem_we       <= 1'b0;
      o_mem_en       <= 1'b0;
      o_mem_width    <= `MEM_WORD;
      o_mem_unsigned <= 1'b0;
      o_reg_wen      <= 1'b0;
      o_mem_to_reg   <= 1'b0;
      o_jump         <= 1'b0;
      o_jalr         <= 1'b0;
      o_branch       <= 1'b0;
      o_alu_op       <= `ALU_ADD;
      o_alu_src1_sel <= `SRC_REG;
      o_alu_src2_sel <= `SRC_IMM;
      o_ebreak       <= 1'b0;
      o_ecall        <= 1'b0;
      o_mret         <= 1'b0;
      o_csr_we       <= 1'b0;
      o_csr_op       <= `CSR_NONE;
      o_illegal      <= 1'b0;
    end else begin
      o_valid        <= 1'b1;
      o_mem_we       <= ctrl.mem_we;
      o_mem_en       <= ctrl.mem_en;
      o_mem_width    <= ctrl.mem_width;
      o_mem_unsigned <= ctrl.mem_unsigned;
      o_reg_wen      <= ctrl.reg_wen;
      o_mem_to_reg   <= ctrl.mem_to_reg;
      o_jump         <= ctrl.jump;
      o_jalr         <= ctrl.jalr;
      o_branch       <= ctrl.branch;
      o_alu_op       <= ctrl.alu_op;
      o_alu_src1_sel <= ctrl.alu_src1_sel;
      o_alu_src2_sel <= ctrl.alu_src2_sel;
      o_ebreak       <= ctrl.ebreak;
      o_ecall        <= ctrl.ecall;
      o_mret         <= ctrl.mret;
      o_csr_we       <= ctrl.csr_we;
      o_csr_op       <= ctrl.csr_op;
      o_illegal      <= ctrl.illegal;
    end
  end

  a_we_has_en: assert property (@(posedge i_clk) disable iff (i_reset)
    o_mem_we |-> o_mem_en);

  // One flow change per instruction
  a_one_flow: assert property (@(posedge i_clk) disable iff (i_reset)
    $onehot0({o_jump, o_branch, o_ecall, o_ebreak, o_mret}));

  // Illegal words carry only the flag
  a_illegal_valid: assert property (@(posedge i_clk) disable iff (i_reset)
    o_illegal |-> o_valid && !(o_mem_en || o_reg_wen || o_jump || o_branch || o_csr_we));
endmodule

// File: rtl/idu_defines.svh
`ifndef IDU_DEFINES_SVH
`define IDU_DEFINES_SVH

`define XLEN   32
`define ILEN   32
`define REG_AW 5
`define CSR_AW 12

// Major opcodes
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_OPIMM  7'b0010011
`define OPC_OP     7'b0110011
`define OPC_BRANCH 7'b1100011
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_SYSTEM 7'b1110011

`define FUNCT7_STD 7'b0000000
`define FUNCT7_ALT 7'b0100000  // SUB and SRA forms

`define SYS_ECALL  12'h000
`define SYS_EBREAK 12'h001
`define MRET_INST  12'h302

`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_SLL  4'd2
`define ALU_SLT  4'd3
`define ALU_SLTU 4'd4
`define ALU_XOR  4'd5
`define ALU_SRL  4'd6
`define ALU_SRA  4'd7
`define ALU_OR   4'd8
`define ALU_AND  4'd9
`define ALU_LUI  4'd10

`define SRC_REG  2'b00
`define SRC_PC   2'b01  // Operand 1 only
`define SRC_IMM  2'b01  // Operand 2 only
`define SRC_ZERO 2'b10

`define MEM_BYTE 2'b00
`define MEM_HALF 2'b01
`define MEM_WORD 2'b10

`define CSR_NONE 2'b00
`define CSR_RW   2'b01
`define CSR_RS   2'b10

`endif

// File: rtl/idu_pkg.sv
package idu_pkg;

  // R-type view
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // I-type view, imm12 doubles as CSR address and system field
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;  // Register fields
    i_fmt_t i;  // CSR and system field
  } inst_u;

endpackage

// File: rtl/idu_top.sv
`timescale 1ns/1ps
`include "idu_defines.svh"

module idu_top (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic [`ILEN-1:0]    i_inst,
  input  logic                i_inst_valid,
  output logic                o_valid,
  output logic [`REG_AW-1:0]  o_rs1_addr,
  output logic [`REG_AW-1:0]  o_rs2_addr,
  output logic [`REG_AW-1:0]  o_rd_addr,
  output logic [2:0]          o_funct3,
  output logic [`CSR_AW-1:0]  o_csr_addr,
  output logic [`XLEN-1:0]    o_imm,
  output logic                o_mem_we,
  output logic                o_mem_en,
  output logic [1:0]          o_mem_width,
  output logic                o_mem_unsigned,
  output logic                o_reg_wen,
  output logic                o_mem_to_reg,
  output logic                o_jump,
  output logic                o_jalr,
  output logic                o_branch,
  output logic [3:0]          o_alu_op,
  output logic [1:0]          o_alu_src1_sel,
  output logic [1:0]          o_alu_src2_sel,
  output logic                o_ebreak,
  output logic                o_ecall,
  output logic                o_mret,
  output logic                o_csr_we,
  output logic [1:0]          o_csr_op,
  output logic                o_illegal
);
  import idu_pkg::*;

  inst_u            w_inst;
  logic [`XLEN-1:0] w_imm;

  dec_if ctrl_bus ();

  assign w_inst = i_inst;  // One word, two views

  imm_gen u_imm_gen (
    .i_inst (w_inst),
    .o_imm  (w_imm)
  );

  ctrl_decode u_ctrl_decode (
    .i_inst (w_inst),
    .ctrl   (ctrl_bus.src)
  );

  dec_reg u_dec_reg (
    .i_valid (i_inst_valid),
    .i_inst  (w_inst),
    .i_imm   (w_imm),
    .ctrl    (ctrl_bus.dst),
    .*                         // Outputs, clock and reset by name
  );
endmodule

// File: rtl/imm_gen.sv
`timescale 1ns/1ps
`include "idu_defines.svh"

module imm_gen (
  input  idu_pkg::inst_u   i_inst,
  output logic [`XLEN-1:0] o_imm
);
  import idu_pkg::*;

  i_fmt_t           w_i;
  logic [`ILEN-1:0] w_raw;
  logic [`XLEN-1:0] w_imm_i;
  logic [`XLEN-1:0] w_imm_s;
  logic [`XLEN-1:0] w_imm_b;
  logic [`XLEN-1:0] w_imm_u;
  logic [`XLEN-1:0] w_imm_j;

  assign w_i   = i_inst.i;
  assign w_raw = i_inst;

  assign w_imm_i = {{20{w_raw[31]}}, w_i.imm12};
  assign w_imm_s = {{20{w_raw[31]}}, w_raw[31:25], w_raw[11:7]};
  assign w_imm_b = {{20{w_raw[31]}}, w_raw[7], w_raw[30:25], w_raw[11:8], 1'b0};
  assign w_imm_u = {w_raw[31:12], 12'b0};
  assign w_imm_j = {{12{w_raw[31]}}, w_raw[19:12], w_raw[20], w_raw[30:21], 1'b0};

  always_comb begin
    case (w_i.opcode)
      `OPC_OPIMM,
      `OPC_LOAD,
      `OPC_JALR:  o_imm = w_imm_i;
      `OPC_STORE: o_imm = w_imm_s;
      `OPC_BRANCH: o_imm = w_imm_b;
      `OPC_LUI,
      `OPC_AUIPC: o_imm = w_imm_u;
      `OPC_JAL:   o_imm = w_imm_j;
      `OPC_OP:    o_imm = '0;
      default:    o_imm = `XLEN'(1);  // SYSTEM and unknown
    endcase
  end
endmodule

// File: vlog.f
+incdir+rtl
rtl/idu_pkg.sv
rtl/dec_if.sv
rtl/imm_gen.sv
rtl/ctrl_decode.sv
rtl/dec_reg.sv
rtl/idu_top.sv
bench/tb_clock.sv
bench/tb_idu.sv
